// File: include/eth_rx_settings.svh
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// station address, first byte on the wire is the top byte
`define ETH_RX_MAC_ADDR 48'h02_00_5E_10_20_30

// frame buffer size in bytes
`define ETH_RX_BUF_DEPTH 2048

// buffer address and byte count width
`define ETH_RX_ADDR_W 11

// CRC register contents after a frame with a correct FCS
`define ETH_RX_CRC_RESIDUE 32'hC704_DD7B

// start frame delimiter as a byte, low nibble first on MII
`define ETH_RX_SFD 8'hD5

`endif

// File: design/eth_rx_pkg.sv
`include "eth_rx_settings.svh"

package eth_rx_pkg;

   typedef logic [7:0]                 eth_byte_t;
   typedef logic [3:0]                 eth_nibble_t;
   typedef logic [`ETH_RX_ADDR_W-1:0]  eth_count_t;
   typedef logic [47:0]                eth_mac_t;
   typedef logic [31:0]                eth_crc_t;

   // framer states
   typedef enum logic [2:0] {
      IDLE,
      DEST,
      DATA,
      CLOSE,
      HOLD,
      DROP
   } framer_state_t;

   // host byte stream
   typedef struct packed {
      eth_byte_t data;
      logic      last;
   } rx_stream_t;

   // per-frame status, valid with the last byte
   typedef struct packed {
      eth_count_t length;
      logic       crc_ok;
   } rx_status_t;

   // one byte write into the frame buffer
   typedef struct packed {
      eth_count_t addr;
      eth_byte_t  data;
      logic       en;
   } buf_wr_t;

endpackage

// File: design/eth_crc32.sv
module eth_crc32 import eth_rx_pkg::*; (
   input  logic      RX_CLK,
   input  logic      buf_rst,
   input  logic      crc_start,
   input  logic      crc_en,
   input  eth_byte_t crc_data,
   output eth_crc_t  crc_value
);

   localparam eth_crc_t POLY = 32'h04C1_1DB7;

   eth_crc_t crc_q;
   eth_crc_t crc_next;

   // eight shift steps per byte
   // data bits enter LSB first, the order they appear on the wire
   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (crc_next[31] ^ crc_data[i]) begin
            crc_next = {crc_next[30:0], 1'b0} ^ POLY;
         end else begin
            crc_next = {crc_next[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge buf_rst) begin
      if (buf_rst) begin
         crc_q <= '1;
      end else if (crc_start) begin
         crc_q <= '1;
      end else if (crc_en) begin
         crc_q <= crc_next;
      end
   end

   // no final inversion, a good frame leaves the residue here
   assign crc_value = crc_q;

endmodule

// File: design/eth_rx_framer.sv
`include "eth_rx_settings.svh"

module eth_rx_framer import eth_rx_pkg::*; (
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  logic        rx_dv,
   input  eth_nibble_t rx_data,
   input  logic        buf_busy,
   output logic        buf_rst,
   output buf_wr_t     buf_wr,
   output logic        frame_commit,
   output rx_status_t  commit_status
);

   localparam eth_count_t LAST_ADDR = eth_count_t'(`ETH_RX_BUF_DEPTH - 1);
   localparam eth_count_t HDR_LEN   = eth_count_t'(6);
   localparam logic [2:0] MAC_BYTES = 3'd6;

   logic [1:0]    rst_sync;
   framer_state_t state;
   eth_nibble_t   nib_lo;
   logic          phase;
   logic [2:0]    sh_cnt;
   eth_mac_t      dest_q;
   eth_mac_t      dest_full;
   eth_count_t    wr_ptr;
   logic          trunc;
   eth_byte_t     cur_byte;
   logic          byte_done;
   logic          addr_match;
   logic          shadow_wr;
   logic          crc_ok;
   logic          crc_start;
   logic          crc_en;
   eth_byte_t     crc_data;
   eth_crc_t      crc_value;

   // reset release synchronizer
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign buf_rst = rst_sync[1];

   // byte formed by the nibble on the pins and the one before it
   assign cur_byte   = {rx_data, nib_lo};
   assign byte_done  = rx_dv && phase;
   assign dest_full  = {dest_q[39:0], cur_byte};
   assign addr_match = (dest_full == `ETH_RX_MAC_ADDR) || (dest_full == '1);
   assign shadow_wr  = (state == DATA) && !byte_done && (sh_cnt != MAC_BYTES);
   assign crc_ok     = (crc_value == `ETH_RX_CRC_RESIDUE) && !trunc;
   assign crc_start  = (state == IDLE);

   always_ff @(posedge RX_CLK) begin
      if (rx_dv) begin
         nib_lo <= rx_data;
      end
      // shadow drains top byte first during DATA
      if ((state == DEST) && byte_done) begin
         dest_q <= dest_full;
      end else if (shadow_wr) begin
         dest_q <= {dest_q[39:0], 8'h00};
      end
      crc_data <= cur_byte;
      if (state == CLOSE) begin
         commit_status <= '{length: wr_ptr, crc_ok: crc_ok};
      end
   end

   always_ff @(posedge RX_CLK or posedge buf_rst) begin
      if (buf_rst) begin
         state        <= IDLE;
         phase        <= 1'b0;
         sh_cnt       <= '0;
         wr_ptr       <= '0;
         trunc        <= 1'b0;
         frame_commit <= 1'b0;
         buf_wr       <= '0;
         crc_en       <= 1'b0;
      end else begin
         buf_wr.en    <= 1'b0;
         frame_commit <= 1'b0;
         crc_en       <= byte_done && ((state == DEST) || (state == DATA));
         if (rx_dv) begin
            phase <= ~phase;
         end
         case (state)
            IDLE: begin
               if (rx_dv && (cur_byte == `ETH_RX_SFD)) begin
                  phase  <= 1'b0;
                  sh_cnt <= '0;
                  state  <= buf_busy ? DROP : DEST;
               end
            end
            DEST: begin
               // fewer than six bytes, nothing to keep
               if (!rx_dv) begin
                  state <= IDLE;
               end else if (byte_done) begin
                  sh_cnt <= sh_cnt + 3'd1;
                  if (sh_cnt == MAC_BYTES - 3'd1) begin
                     sh_cnt <= '0;
                     wr_ptr <= HDR_LEN;
                     trunc  <= 1'b0;
                     state  <= addr_match ? DATA : DROP;
                  end
               end
            end
            DATA: begin
               if (byte_done) begin
                  if (wr_ptr == LAST_ADDR) begin
                     trunc <= 1'b1;
                  end else begin
                     buf_wr <= '{addr: wr_ptr, data: cur_byte, en: 1'b1};
                     wr_ptr <= wr_ptr + eth_count_t'(1);
                  end
               end else if (shadow_wr) begin
                  // header bytes go in on the idle half of each byte
                  buf_wr <= '{addr: eth_count_t'(sh_cnt), data: dest_q[47:40], en: 1'b1};
                  sh_cnt <= sh_cnt + 3'd1;
               end
               if (!rx_dv) begin
                  state <= (wr_ptr == HDR_LEN) ? IDLE : CLOSE;
               end
            end
            CLOSE: begin
               frame_commit <= 1'b1;
               state        <= HOLD;
            end
            HOLD: begin
               if (rx_dv) begin
                  state <= DROP;
               end else if (!buf_busy) begin
                  state <= IDLE;
               end
            end
            DROP: begin
               if (!rx_dv) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   eth_crc32 u_crc (
      .RX_CLK    (RX_CLK),
      .buf_rst   (buf_rst),
      .crc_start (crc_start),
      .crc_en    (crc_en),
      .crc_data  (crc_data),
      .crc_value (crc_value)
   );

endmodule

// File: design/eth_rx_frame_buf.sv
`include "eth_rx_settings.svh"

module eth_rx_frame_buf import eth_rx_pkg::*; (
   input  logic       RX_CLK,
   input  logic       buf_rst,
   input  buf_wr_t    buf_wr,
   input  logic       frame_commit,
   input  rx_status_t commit_status,
   output logic       buf_busy,
   output logic       out_valid,
   input  logic       out_ready,
   output rx_stream_t out_stream,
   output rx_status_t out_status
);

   eth_byte_t  mem [`ETH_RX_BUF_DEPTH];
   eth_byte_t  rd_data;
   eth_count_t rd_ptr;
   eth_count_t rd_addr;
   logic       rd_en;
   logic       take;
   logic       last_byte;
   rx_status_t status_q;

   assign take      = out_valid && out_ready;
   assign last_byte = (rd_ptr == status_q.length - eth_count_t'(1));

   // read one byte ahead so an accepted byte is replaced next cycle
   assign rd_en   = frame_commit || (take && !last_byte);
   assign rd_addr = frame_commit ? '0 : rd_ptr + eth_count_t'(1);

   always_ff @(posedge RX_CLK) begin
      if (buf_wr.en) begin
         mem[buf_wr.addr] <= buf_wr.data;
      end
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
      if (frame_commit) begin
         status_q <= commit_status;
      end
   end

   always_ff @(posedge RX_CLK or posedge buf_rst) begin
      if (buf_rst) begin
         out_valid <= 1'b0;
         rd_ptr    <= '0;
      end else if (frame_commit) begin
         out_valid <= 1'b1;
         rd_ptr    <= rd_addr;
      end else if (take) begin
         if (last_byte) begin
            out_valid <= 1'b0;
         end else begin
            rd_ptr <= rd_addr;
         end
      end
   end

   // owned by the reader from commit through the final handshake
   assign buf_busy   = frame_commit || out_valid;
   assign out_stream = '{data: rd_data, last: last_byte};
   assign out_status = status_q;

endmodule

// File: design/eth_rx_top.sv
module eth_rx_top import eth_rx_pkg::*; (
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  logic        rx_dv,
   input  eth_nibble_t rx_data,
   output logic        out_valid,
   input  logic        out_ready,
   output rx_stream_t  out_stream,
   output rx_status_t  out_status
);

   logic       buf_rst;
   buf_wr_t    buf_wr;
   logic       frame_commit;
   rx_status_t commit_status;
   logic       buf_busy;

   // MII side, CRC lives inside
   eth_rx_framer u_framer (
      .RX_CLK        (RX_CLK),
      .rx_rst        (rx_rst),
      .rx_dv         (rx_dv),
      .rx_data       (rx_data),
      .buf_busy      (buf_busy),
      .buf_rst       (buf_rst),
      .buf_wr        (buf_wr),
      .frame_commit  (frame_commit),
      .commit_status (commit_status)
   );

   // host side stream
   eth_rx_frame_buf u_buf (
      .RX_CLK        (RX_CLK),
      .buf_rst       (buf_rst),
      .buf_wr        (buf_wr),
      .frame_commit  (frame_commit),
      .commit_status (commit_status),
      .buf_busy      (buf_busy),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_stream    (out_stream),
      .out_status    (out_status)
   );

endmodule

// File: tests/eth_rx_clk_gen.sv
module eth_rx_clk_gen (
   output logic RX_CLK,
   output logic rx_rst
);

   timeunit 1ns;
   timeprecision 100ps;

   // 50 MHz receive clock
   initial begin
      RX_CLK = 1'b0;
      forever begin
         #10 RX_CLK = ~RX_CLK;
      end
   end

   // reset held for three clock cycles
   initial begin
      rx_rst = 1'b1;
      repeat (3) @(posedge RX_CLK);
      rx_rst <= 1'b0;
   end

endmodule

// File: tests/eth_rx_assertions.sv
module eth_rx_assertions import eth_rx_pkg::*; (
   input logic       RX_CLK,
   input logic       buf_rst,
   input buf_wr_t    buf_wr,
   input logic       buf_busy,
   input logic       out_valid,
   input logic       out_ready,
   input rx_stream_t out_stream
);

   timeunit 1ns;
   timeprecision 100ps;

   // failures seen so far, read by the testbench at the end
   int fail_cnt = 0;

   // a stalled byte stays put until the host takes it
   stall_stable: assert property (@(posedge RX_CLK) disable iff (buf_rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_stream)))
   else begin
      fail_cnt++;
      $error("out_valid or out_stream changed while the host stalled");
   end

   reset_idle: assert property (@(posedge RX_CLK) buf_rst |-> !out_valid)
   else begin
      fail_cnt++;
      $error("out_valid high during reset");
   end

   // buffer owned by the reader
   no_write_busy: assert property (@(posedge RX_CLK) disable iff (buf_rst)
      buf_busy |-> !buf_wr.en)
   else begin
      fail_cnt++;
      $error("buffer write while the frame is being read out");
   end

endmodule

bind eth_rx_frame_buf eth_rx_assertions u_assert (
   .RX_CLK     (RX_CLK),
   .buf_rst    (buf_rst),
   .buf_wr     (buf_wr),
   .buf_busy   (buf_busy),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_stream (out_stream)
);

// File: tests/eth_rx_tb.sv
module eth_rx_tb import eth_rx_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_FRAMES = 16;
   localparam int QUIET_CYCLES = 12;

   logic        RX_CLK;
   logic        rx_rst;
   logic        rx_dv;
   eth_nibble_t rx_data;
   logic        out_valid;
   logic        out_ready;
   rx_stream_t  out_stream;
   rx_status_t  out_status;

   logic [47:0] stim_mem [4*MAX_FRAMES];
   integer      seed;
   int          err_count;
   int          test_count;
   int          pass_count;
   logic        stop_run;
   // accepted frame still sitting in the DUT buffer
   eth_byte_t   pend_bytes [$];
   logic        pend_valid;
   logic        pend_crc_ok;
   // tests whose checks finish at the next readout
   int          grp_ids [$];
   int          grp_err;

   eth_rx_clk_gen u_clk (
      .RX_CLK (RX_CLK),
      .rx_rst (rx_rst)
   );

   eth_rx_top u_dut (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_stream (out_stream),
      .out_status (out_status)
   );

   // IEEE 802.3 FCS, reflected form with final inversion
   function automatic eth_crc_t fcs_of(input eth_byte_t bytes [$]);
      eth_crc_t crc;
      crc = 32'hFFFF_FFFF;
      foreach (bytes[i]) begin
         crc = crc ^ {24'h0, bytes[i]};
         for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
         end
      end
      return ~crc;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      err_count++;
      $display("%s", msg);
   endtask

   task automatic build_frame(input logic [47:0] dest, input int len, input logic corrupt,
                              output eth_byte_t bytes [$]);
      eth_crc_t fcs;
      bytes = {};
      for (int i = 5; i >= 0; i--) begin
         bytes.push_back(dest[8*i +: 8]);
      end
      // source address and payload
      for (int i = 0; i < 6 + len; i++) begin
         bytes.push_back(eth_byte_t'($random(seed)));
      end
      fcs = fcs_of(bytes);
      if (corrupt) begin
         fcs = fcs ^ 32'h0000_0100;
      end
      for (int i = 0; i < 4; i++) begin
         bytes.push_back(fcs[8*i +: 8]);
      end
   endtask

   task automatic drive_nibble(input eth_nibble_t nib);
      @(posedge RX_CLK);
      rx_dv   <= 1'b1;
      rx_data <= nib;
   endtask

   task automatic send_frame(input eth_byte_t bytes [$]);
      // preamble and SFD, fifteen 5s then D
      for (int i = 0; i < 15; i++) begin
         drive_nibble(4'h5);
      end
      drive_nibble(4'hD);
      foreach (bytes[i]) begin
         drive_nibble(bytes[i][3:0]);
         drive_nibble(bytes[i][7:4]);
      end
      @(posedge RX_CLK);
      rx_dv   <= 1'b0;
      rx_data <= '0;
      repeat (12) @(posedge RX_CLK);
   endtask

   task automatic drain_frame();
      int   idx;
      int   cycles;
      int   limit;
      logic done;
      idx    = 0;
      cycles = 0;
      done   = 1'b0;
      limit  = 64 + 8 * pend_bytes.size();
      while (!done && cycles < limit) begin
         @(negedge RX_CLK);
         if (out_valid && out_ready) begin
            if (idx >= pend_bytes.size()) begin
               report_failure($sformatf("stream runs past the %0d byte frame", pend_bytes.size()));
               done = 1'b1;
            end else begin
               check_val("out_stream.data", out_stream.data, pend_bytes[idx]);
               check_val("out_stream.last", out_stream.last, idx == pend_bytes.size() - 1);
               if (out_stream.last) begin
                  check_val("out_status.length", out_status.length, pend_bytes.size());
                  check_val("out_status.crc_ok", out_status.crc_ok, pend_crc_ok);
                  done = 1'b1;
               end
            end
            idx++;
         end
         @(posedge RX_CLK);
         out_ready <= done ? 1'b0 : (($random(seed) & 3) != 0);
         cycles++;
      end
      if (!done) begin
         report_failure($sformatf("timeout after %0d bytes of the frame readout", idx));
         stop_run = 1'b1;
      end
      pend_valid = 1'b0;
   endtask

   // nothing may come out of the buffer
   task automatic expect_quiet();
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < QUIET_CYCLES; i++) begin
         @(negedge RX_CLK);
         seen = seen || out_valid;
      end
      if (seen) begin
         report_failure("a dropped frame showed up on the output stream");
      end
   endtask

   task automatic report_tests();
      foreach (grp_ids[i]) begin
         test_count++;
         if (err_count == grp_err) begin
            pass_count++;
            $display("frame %0d: ok", grp_ids[i]);
         end else begin
            $display("frame %0d: errors found", grp_ids[i]);
         end
      end
      grp_ids = {};
      grp_err = err_count;
   endtask

   initial begin
      int          n;
      int          len;
      int          kind;
      int          waited;
      logic        corrupt;
      eth_byte_t   bytes [$];
      seed       = 32'h366d_8146;
      rx_dv      = 1'b0;
      rx_data    = '0;
      out_ready  = 1'b0;
      err_count  = 0;
      test_count = 0;
      pass_count = 0;
      grp_err    = 0;
      stop_run   = 1'b0;
      pend_valid = 1'b0;
      $readmemh("tests/eth_rx_stim.txt", stim_mem);
      waited = 0;
      while (rx_rst !== 1'b0 && waited < 50) begin
         @(posedge RX_CLK);
         waited++;
      end
      if (rx_rst !== 1'b0) begin
         report_failure("reset was never released");
         stop_run = 1'b1;
      end
      // synchronized reset inside the framer trails by two cycles
      repeat (4) @(posedge RX_CLK);
      n = 0;
      while (!stop_run && n < MAX_FRAMES && !$isunknown(stim_mem[4*n])) begin
         len     = int'(stim_mem[4*n+1]);
         corrupt = stim_mem[4*n+2][0];
         kind    = int'(stim_mem[4*n+3]);
         // kind 2 is sent on top of the unread frame
         if (pend_valid && kind != 2) begin
            drain_frame();
            if (!stop_run) begin
               expect_quiet();
            end
            report_tests();
         end
         build_frame(stim_mem[4*n], len, corrupt, bytes);
         grp_ids.push_back(n + 1);
         send_frame(bytes);
         if (kind == 1) begin
            pend_bytes  = bytes;
            pend_crc_ok = !corrupt;
            pend_valid  = 1'b1;
         end else if (kind == 0) begin
            expect_quiet();
            report_tests();
         end
         n++;
      end
      if (pend_valid && !stop_run) begin
         drain_frame();
         if (!stop_run) begin
            expect_quiet();
         end
      end
      report_tests();
      if (test_count == 0) begin
         report_failure("no frames were read from the stim file");
      end
      err_count += u_dut.u_buf.u_assert.fail_cnt;
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               test_count, pass_count, test_count - pass_count, err_count);
      if (err_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: tests/eth_rx_stim.txt
// dest_mac  payload_len  corrupt_fcs  kind
// kind 1 delivered, 0 filtered out, 2 sent while the previous frame is unread
02005e102030 2e 0 1
ffffffffffff 30 0 1
02005e102030 40 1 1
02005e102031 2e 0 0
02005e102030 3c 0 1
02005e102030 2e 0 2
ffffffffffff 64 0 1
02005e102030 80 0 1
0a0b0c0d0e0f 2e 0 0
02005e102030 2e 1 1

// File: eth_rx.f
+incdir+include
design/eth_rx_pkg.sv
design/eth_crc32.sv
design/eth_rx_framer.sv
design/eth_rx_frame_buf.sv
design/eth_rx_top.sv
tests/eth_rx_clk_gen.sv
tests/eth_rx_assertions.sv
tests/eth_rx_tb.sv

// File: Bender.yml
package:
  name: eth_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/eth_rx_pkg.sv
      - design/eth_crc32.sv
      - design/eth_rx_framer.sv
      - design/eth_rx_frame_buf.sv
      - design/eth_rx_top.sv
  - target: test
    files:
      - tests/eth_rx_clk_gen.sv
      - tests/eth_rx_assertions.sv
      - tests/eth_rx_tb.sv
